// ==== source/pi_cmd_pkg.sv ====
package pi_cmd_pkg;

    // field widths of the parameter set
    localparam int coef_width = 27;
    localparam int limit_width = 14;

    // command datagram payload and reply payload, in bytes
    localparam int cmd_length = 8;
    localparam int reply_length = 4;

    // status word of the MAC/UDP FIFOs, same layout rx and tx
    typedef struct packed {
        logic [47:0] peer_mac;
        logic [31:0] peer_ip;
        // payload bytes
        logic [15:0] length;
    } udp_status_t;

    typedef enum logic [7:0] {
        op_pi_enable = 8'h01,
        op_pi_reset  = 8'h02,
        op_kp        = 8'h10,
        op_ti        = 8'h11,
        op_setpoint  = 8'h12,
        op_limit_hi  = 8'h13,
        op_limit_lo  = 8'h14,
        op_wipe      = 8'h1F
    } opcode_e;

    typedef enum logic [7:0] {
        res_ack = 8'h06,
        res_nak = 8'h15,
        res_err = 8'hEE
    } result_e;

    // one parsed command, seq is echoed back in the reply
    typedef struct packed {
        logic [7:0]  opcode;
        logic [7:0]  seq;
        logic [31:0] data;
    } cmd_word_t;

    // valid is a single-cycle strobe
    typedef struct packed {
        logic    valid;
        result_e code;
    } cmd_result_t;

    typedef struct packed {
        logic [coef_width-1:0]  kp;
        logic [coef_width-1:0]  ti;
        logic [coef_width-1:0]  setpoint;
        logic [limit_width-1:0] limit_hi;
        logic [limit_width-1:0] limit_lo;
    } pi_params_t;

    // values after reset and after a wipe command
    localparam pi_params_t params_default = '{
        kp:       '0,
        ti:       '0,
        setpoint: '0,
        limit_hi: '1,
        limit_lo: '0
    };
    localparam logic flag_default = 1'b0;

endpackage

// ==== source/udp_cmd_parser.sv ====
`timescale 1ns/1ps

module udp_cmd_parser (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [7:0]              rx_data,
    output logic                    rx_data_read,
    input  pi_cmd_pkg::udp_status_t rx_status,
    input  logic                    rx_status_empty,
    output logic                    rx_status_read,
    input  logic                    reply_busy,
    output pi_cmd_pkg::cmd_word_t   cmd,
    output pi_cmd_pkg::udp_status_t peer,
    output logic                    flag_enable_valid,
    output logic                    flag_reset_valid,
    output logic                    control_valid,
    output logic                    wipe,
    output pi_cmd_pkg::cmd_result_t parser_result
);
    import pi_cmd_pkg::*;

    // st_wait gives the decoders one cycle to report before the next pop
    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_dispatch,
        st_wait
    } state_e;

    state_e      state;
    logic [15:0] byte_idx;
    logic        length_ok;
    logic        known_op;
    logic        is_control;
    logic        dispatch_ok;

    // show-ahead FIFOs, so the pop happens in the cycle the word is used
    assign rx_status_read = (state == st_idle) && !rx_status_empty && !reply_busy;
    assign rx_data_read = (state == st_read);

    // only full 8-byte commands reach a decoder
    assign length_ok = (peer.length == 16'(cmd_length));
    assign dispatch_ok = (state == st_dispatch) && length_ok;

    // opcode classes
    always_comb begin
        is_control = 1'b0;
        known_op = 1'b1;
        case (cmd.opcode)
            op_pi_enable, op_pi_reset, op_wipe: begin
                is_control = 1'b0;
            end
            op_kp, op_ti, op_setpoint, op_limit_hi, op_limit_lo: begin
                is_control = 1'b1;
            end
            default: begin
                known_op = 1'b0;
            end
        endcase
    end

    // exactly one strobe per good command
    assign flag_enable_valid = dispatch_ok && (cmd.opcode == op_pi_enable);
    assign flag_reset_valid = dispatch_ok && (cmd.opcode == op_pi_reset);
    assign control_valid = dispatch_ok && is_control;
    assign wipe = dispatch_ok && (cmd.opcode == op_wipe);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            byte_idx <= '0;
            parser_result <= '{valid: 1'b0, code: res_err};
        end else begin
            parser_result.valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (rx_status_read) begin
                        byte_idx <= '0;
                        // empty datagram goes straight to the err reply
                        state <= (rx_status.length == 16'd0) ? st_dispatch : st_read;
                    end
                end
                st_read: begin
                    byte_idx <= byte_idx + 16'd1;
                    // drain every byte, whatever the length
                    if (byte_idx == peer.length - 16'd1) begin
                        state <= st_dispatch;
                    end
                end
                st_dispatch: begin
                    // bad length or unknown opcode, answered here
                    parser_result.valid <= !(length_ok && known_op);
                    state <= st_wait;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // payload capture, data field arrives msb first
    always_ff @(posedge clk) begin
        if (rx_status_read) begin
            peer <= rx_status;
            cmd <= '0;
        end else if (rx_data_read) begin
            case (byte_idx)
                16'd0: cmd.opcode <= rx_data;
                16'd1: cmd.seq <= rx_data;
                // bytes 2 and 3 reserved
                16'd4, 16'd5, 16'd6, 16'd7: cmd.data <= {cmd.data[23:0], rx_data};
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== source/flag_cmd_decoder.sv ====
`timescale 1ns/1ps

module flag_cmd_decoder (
    input  logic                    clk,
    input  logic                    rst_n,
    input  pi_cmd_pkg::cmd_word_t   cmd,
    input  logic                    cmd_valid,
    input  logic                    wipe,
    output logic                    flag,
    output pi_cmd_pkg::cmd_result_t result
);
    import pi_cmd_pkg::*;

    logic data_ok;

    // only 0 and 1 are legal flag values
    assign data_ok = (cmd.data[31:1] == 31'd0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flag <= flag_default;
            result <= '{valid: 1'b0, code: res_ack};
        end else begin
            // one result per command, none for wipe
            result.valid <= cmd_valid;
            if (wipe) begin
                flag <= flag_default;
            end else if (cmd_valid) begin
                if (data_ok) begin
                    flag <= cmd.data[0];
                    result.code <= res_ack;
                end else begin
                    // flag keeps its value
                    result.code <= res_nak;
                end
            end
        end
    end

endmodule

// ==== source/control_param_decoder.sv ====
`timescale 1ns/1ps

module control_param_decoder (
    input  logic                    clk,
    input  logic                    rst_n,
    input  pi_cmd_pkg::cmd_word_t   cmd,
    input  logic                    cmd_valid,
    input  logic                    wipe,
    input  logic                    dac_stopped,
    output pi_cmd_pkg::pi_params_t  params,
    output logic                    kp_update_cmd,
    output logic                    ti_update_cmd,
    output logic                    setpoint_update_cmd,
    output pi_cmd_pkg::cmd_result_t result
);
    import pi_cmd_pkg::*;

    logic                   fits_coef;
    logic                   fits_limit;
    logic [limit_width-1:0] new_limit;
    logic                   accept;

    // upper data bits must be clear for the target field
    assign fits_coef = (cmd.data[31:coef_width] == '0);
    assign fits_limit = (cmd.data[31:limit_width] == '0);
    assign new_limit = cmd.data[limit_width-1:0];

    // acceptance rules per opcode
    always_comb begin
        accept = 1'b0;
        case (cmd.opcode)
            // coefficients only with the DAC stopped
            op_kp, op_ti: accept = fits_coef && dac_stopped;
            // setpoint may change while running
            op_setpoint: accept = fits_coef;
            // limits must stay ordered, hi >= lo
            op_limit_hi: accept = fits_limit && dac_stopped && (new_limit >= params.limit_lo);
            op_limit_lo: accept = fits_limit && dac_stopped && (new_limit <= params.limit_hi);
            default: accept = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            params <= params_default;
            kp_update_cmd <= 1'b0;
            ti_update_cmd <= 1'b0;
            setpoint_update_cmd <= 1'b0;
            result <= '{valid: 1'b0, code: res_ack};
        end else begin
            // update pulses last a single cycle
            kp_update_cmd <= 1'b0;
            ti_update_cmd <= 1'b0;
            setpoint_update_cmd <= 1'b0;
            result.valid <= cmd_valid || wipe;
            if (wipe) begin
                // defaults back, always acknowledged
                params <= params_default;
                result.code <= res_ack;
            end else if (cmd_valid) begin
                result.code <= accept ? res_ack : res_nak;
                if (accept) begin
                    case (cmd.opcode)
                        op_kp: begin
                            params.kp <= cmd.data[coef_width-1:0];
                            kp_update_cmd <= 1'b1;
                        end
                        op_ti: begin
                            params.ti <= cmd.data[coef_width-1:0];
                            ti_update_cmd <= 1'b1;
                        end
                        op_setpoint: begin
                            params.setpoint <= cmd.data[coef_width-1:0];
                            setpoint_update_cmd <= 1'b1;
                        end
                        op_limit_hi: params.limit_hi <= new_limit;
                        op_limit_lo: params.limit_lo <= new_limit;
                        default: begin
                        end
                    endcase
                end
            end
        end
    end

endmodule

// ==== source/ack_frame_builder.sv ====
`timescale 1ns/1ps

module ack_frame_builder (
    input  logic                    clk,
    input  logic                    rst_n,
    input  pi_cmd_pkg::cmd_word_t   cmd,
    input  pi_cmd_pkg::udp_status_t peer,
    input  pi_cmd_pkg::cmd_result_t parser_result,
    input  pi_cmd_pkg::cmd_result_t enable_result,
    input  pi_cmd_pkg::cmd_result_t reset_result,
    input  pi_cmd_pkg::cmd_result_t control_result,
    output logic                    reply_busy,
    output logic [7:0]              tx_data,
    output logic                    tx_data_write,
    input  logic                    tx_data_full,
    output pi_cmd_pkg::udp_status_t tx_status,
    output logic                    tx_status_write,
    input  logic                    tx_status_full
);
    import pi_cmd_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_data,
        st_status
    } state_e;

    state_e      state;
    logic [1:0]  byte_idx;
    logic [7:0]  reply_opcode;
    logic [7:0]  reply_seq;
    result_e     reply_code;
    udp_status_t reply_peer;
    logic        any_valid;
    logic [7:0]  merged_code;

    // at most one result is valid per command
    assign any_valid = parser_result.valid || enable_result.valid ||
                       reset_result.valid || control_result.valid;

    always_comb begin
        merged_code = 8'h00;
        if (parser_result.valid) begin
            merged_code |= parser_result.code;
        end
        if (enable_result.valid) begin
            merged_code |= enable_result.code;
        end
        if (reset_result.valid) begin
            merged_code |= reset_result.code;
        end
        if (control_result.valid) begin
            merged_code |= control_result.code;
        end
    end

    assign reply_busy = (state != st_idle);

    // reply bytes: opcode, seq, result, pad
    always_comb begin
        case (byte_idx)
            2'd0: tx_data = reply_opcode;
            2'd1: tx_data = reply_seq;
            2'd2: tx_data = reply_code;
            default: tx_data = 8'h00;
        endcase
    end

    // writes only while the FIFOs have room
    assign tx_data_write = (state == st_data) && !tx_data_full;
    assign tx_status_write = (state == st_status) && !tx_status_full;

    // reply goes back to the sender
    assign tx_status = '{
        peer_mac: reply_peer.peer_mac,
        peer_ip:  reply_peer.peer_ip,
        length:   16'(reply_length)
    };

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            byte_idx <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (any_valid) begin
                        byte_idx <= '0;
                        state <= st_data;
                    end
                end
                st_data: begin
                    if (tx_data_write) begin
                        byte_idx <= byte_idx + 2'd1;
                        if (byte_idx == 2'(reply_length - 1)) begin
                            state <= st_status;
                        end
                    end
                end
                st_status: begin
                    // status word closes the datagram
                    if (tx_status_write) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // reply fields latched with the result
    always_ff @(posedge clk) begin
        if ((state == st_idle) && any_valid) begin
            reply_opcode <= cmd.opcode;
            reply_seq <= cmd.seq;
            reply_code <= result_e'(merged_code);
            reply_peer <= peer;
        end
    end

endmodule

// ==== source/pi_cmd_top.sv ====
`timescale 1ns/1ps

module pi_cmd_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    dac_stopped,
    input  logic [7:0]              rx_data,
    output logic                    rx_data_read,
    input  pi_cmd_pkg::udp_status_t rx_status,
    input  logic                    rx_status_empty,
    output logic                    rx_status_read,
    output logic [7:0]              tx_data,
    output logic                    tx_data_write,
    input  logic                    tx_data_full,
    output pi_cmd_pkg::udp_status_t tx_status,
    output logic                    tx_status_write,
    input  logic                    tx_status_full,
    output logic                    pi_enable_cmd,
    output logic                    pi_reset_cmd,
    output pi_cmd_pkg::pi_params_t  pi_params,
    output logic                    kp_update_cmd,
    output logic                    ti_update_cmd,
    output logic                    setpoint_update_cmd
);
    import pi_cmd_pkg::*;

    // parser outputs shared by all decoders
    cmd_word_t   cmd;
    udp_status_t peer;
    logic        flag_enable_valid;
    logic        flag_reset_valid;
    logic        control_valid;
    logic        wipe;

    // results toward the reply path
    cmd_result_t parser_result;
    cmd_result_t enable_result;
    cmd_result_t reset_result;
    cmd_result_t control_result;
    logic        reply_busy;

    udp_cmd_parser parser (
        .clk(clk), .rst_n(rst_n),
        .rx_data(rx_data), .rx_data_read(rx_data_read),
        .rx_status(rx_status), .rx_status_empty(rx_status_empty),
        .rx_status_read(rx_status_read), .reply_busy(reply_busy),
        .cmd(cmd), .peer(peer),
        .flag_enable_valid(flag_enable_valid), .flag_reset_valid(flag_reset_valid),
        .control_valid(control_valid), .wipe(wipe), .parser_result(parser_result)
    );

    // same decoder for both PI flags
    flag_cmd_decoder enable_decoder (
        .clk(clk), .rst_n(rst_n), .cmd(cmd), .cmd_valid(flag_enable_valid),
        .wipe(wipe), .flag(pi_enable_cmd), .result(enable_result)
    );

    flag_cmd_decoder reset_decoder (
        .clk(clk), .rst_n(rst_n), .cmd(cmd), .cmd_valid(flag_reset_valid),
        .wipe(wipe), .flag(pi_reset_cmd), .result(reset_result)
    );

    control_param_decoder control_decoder (
        .clk(clk), .rst_n(rst_n), .cmd(cmd), .cmd_valid(control_valid),
        .wipe(wipe), .dac_stopped(dac_stopped), .params(pi_params),
        .kp_update_cmd(kp_update_cmd), .ti_update_cmd(ti_update_cmd),
        .setpoint_update_cmd(setpoint_update_cmd), .result(control_result)
    );

    ack_frame_builder builder (
        .clk(clk), .rst_n(rst_n), .cmd(cmd), .peer(peer),
        .parser_result(parser_result), .enable_result(enable_result),
        .reset_result(reset_result), .control_result(control_result),
        .reply_busy(reply_busy),
        .tx_data(tx_data), .tx_data_write(tx_data_write), .tx_data_full(tx_data_full),
        .tx_status(tx_status), .tx_status_write(tx_status_write),
        .tx_status_full(tx_status_full)
    );

endmodule

// ==== verification/pi_cmd_model.svh ====
// expected DUT state, advanced per command in the order commands are queued
pi_params_t exp_params;
logic       exp_enable;
logic       exp_reset;
int         exp_kp_pulses = 0;
int         exp_ti_pulses = 0;
int         exp_sp_pulses = 0;

// values after reset and after wipe
function automatic void reset_expected();
    exp_params.kp = '0;
    exp_params.ti = '0;
    exp_params.setpoint = '0;
    exp_params.limit_hi = 14'h3FFF;
    exp_params.limit_lo = '0;
    exp_enable = 1'b0;
    exp_reset = 1'b0;
endfunction

// result code of one datagram, state updated as the decoders should
function automatic logic [7:0] apply_command(input logic [7:0] opcode, input logic [31:0] data,
                                             input int length, input logic dac);
    logic coef_ok;
    logic limit_ok;
    coef_ok = (data < 32'h0800_0000);
    limit_ok = (data < 32'h0000_4000);
    // wrong length never reaches a decoder
    if (length != 8) begin
        return res_err;
    end
    case (opcode)
        op_pi_enable, op_pi_reset: begin
            if (data > 32'd1) begin
                return res_nak;
            end
            if (opcode == op_pi_enable) exp_enable = data[0];
            else exp_reset = data[0];
            return res_ack;
        end
        op_kp, op_ti: begin
            if (!(coef_ok && dac)) begin
                return res_nak;
            end
            if (opcode == op_kp) begin
                exp_params.kp = data[26:0];
                exp_kp_pulses++;
            end else begin
                exp_params.ti = data[26:0];
                exp_ti_pulses++;
            end
            return res_ack;
        end
        op_setpoint: begin
            // allowed while running
            if (!coef_ok) begin
                return res_nak;
            end
            exp_params.setpoint = data[26:0];
            exp_sp_pulses++;
            return res_ack;
        end
        op_limit_hi: begin
            if (!(limit_ok && dac && data[13:0] >= exp_params.limit_lo)) begin
                return res_nak;
            end
            exp_params.limit_hi = data[13:0];
            return res_ack;
        end
        op_limit_lo: begin
            if (!(limit_ok && dac && data[13:0] <= exp_params.limit_hi)) begin
                return res_nak;
            end
            exp_params.limit_lo = data[13:0];
            return res_ack;
        end
        op_wipe: begin
            reset_expected();
            return res_ack;
        end
        default: return res_err;
    endcase
endfunction

// ==== verification/pi_cmd_tb.sv ====
`timescale 1ns/1ps

module pi_cmd_tb;
    import pi_cmd_pkg::*;

    // commands per test, the watchdog scales with the sum
    localparam int n_flag = 40;
    localparam int n_ctrl = 60;
    localparam int n_bad = 15;
    localparam int n_wipe = 10;
    localparam int n_burst = 30;
    localparam int n_cmds = n_flag + n_ctrl + 2 * n_bad + n_wipe + 3 + n_burst;

    logic        clk;
    logic        rst_n;
    logic        dac_stopped;
    logic [7:0]  rx_data;
    logic        rx_data_read;
    udp_status_t rx_status;
    logic        rx_status_empty;
    logic        rx_status_read;
    logic [7:0]  tx_data;
    logic        tx_data_write;
    logic        tx_data_full;
    udp_status_t tx_status;
    logic        tx_status_write;
    logic        tx_status_full;
    logic        pi_enable_cmd;
    logic        pi_reset_cmd;
    pi_params_t  pi_params;
    logic        kp_update_cmd;
    logic        ti_update_cmd;
    logic        setpoint_update_cmd;

    // fifo contents, both directions
    logic [7:0]  rx_byte_q[$];
    udp_status_t rx_stat_q[$];
    logic [7:0]  tx_byte_q[$];
    udp_status_t tx_stat_q[$];
    // replies expected, request order
    logic [31:0] exp_reply_q[$];
    udp_status_t exp_peer_q[$];

    logic dac_level;
    int   kp_pulses = 0;
    int   ti_pulses = 0;
    int   sp_pulses = 0;
    int   checks = 0;
    int   test_errors = 0;
    int   errors = 0;
    int   tests = 0;
    int   failed_tests = 0;

    `include "pi_cmd_model.svh"

    pi_cmd_top i_pi_cmd_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // hang guard, 200 cycles per command
    initial begin
        #(n_cmds * 200 * 20);
        $display("timeout: the DUT stopped answering before all commands were replied to");
        $display("TEST FAILED");
        $finish;
    end

    // one clock: sample outputs, update fifo models, drive inputs
    task automatic tick();
        @(posedge clk);
        if (rx_status_read) begin
            void'(rx_stat_q.pop_front());
        end
        if (rx_data_read) begin
            void'(rx_byte_q.pop_front());
        end
        if (tx_data_write) begin
            tx_byte_q.push_back(tx_data);
        end
        if (tx_status_write) begin
            tx_stat_q.push_back(tx_status);
        end
        if (kp_update_cmd) kp_pulses++;
        if (ti_update_cmd) ti_pulses++;
        if (setpoint_update_cmd) sp_pulses++;
        // show-ahead, queue heads always visible
        rx_data <= (rx_byte_q.size() > 0) ? rx_byte_q[0] : 8'h00;
        if (rx_stat_q.size() > 0) begin
            rx_status <= rx_stat_q[0];
        end else begin
            rx_status <= '0;
        end
        rx_status_empty <= (rx_stat_q.size() == 0);
        // random back-pressure
        tx_data_full <= ($urandom % 4 == 0);
        tx_status_full <= ($urandom % 3 == 0);
    endtask

    task automatic expect_hex(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic set_dac(input logic v);
        dac_level = v;
        dac_stopped <= v;
    endtask

    // queue one datagram and its expected reply
    task automatic send_cmd(input logic [7:0] opcode, input logic [31:0] data, input int length);
        logic [7:0]  seq;
        logic [63:0] frame;
        logic [7:0]  code;
        udp_status_t st;
        udp_status_t reply_st;
        seq = 8'($urandom);
        st.peer_mac = {16'h0200, 32'($urandom)};
        st.peer_ip = {8'd10, 24'($urandom)};
        st.length = 16'(length);
        // opcode, seq, two spare bytes, data msb first
        frame = {opcode, seq, 16'($urandom), data};
        for (int i = 0; i < length; i++) begin
            if (i < 8) rx_byte_q.push_back(frame[63 - 8 * i -: 8]);
            else rx_byte_q.push_back(8'($urandom));
        end
        rx_stat_q.push_back(st);
        code = apply_command(opcode, data, length, dac_level);
        // short datagrams leave opcode and seq zero
        exp_reply_q.push_back({(length > 0) ? opcode : 8'h00, (length > 1) ? seq : 8'h00,
                               code, 8'h00});
        reply_st.peer_mac = st.peer_mac;
        reply_st.peer_ip = st.peer_ip;
        reply_st.length = 16'd4;
        exp_peer_q.push_back(reply_st);
    endtask

    task automatic verify_replies();
        logic [31:0] got_word;
        udp_status_t got_st;
        udp_status_t exp_st;
        expect_hex("reply byte count", 128'(tx_byte_q.size()), 128'(4 * exp_reply_q.size()));
        expect_hex("reply status count", 128'(tx_stat_q.size()), 128'(exp_peer_q.size()));
        while (exp_reply_q.size() > 0 && tx_stat_q.size() > 0 && tx_byte_q.size() >= 4) begin
            got_word = {tx_byte_q[0], tx_byte_q[1], tx_byte_q[2], tx_byte_q[3]};
            repeat (4) void'(tx_byte_q.pop_front());
            expect_hex("tx_data", 128'(got_word), 128'(exp_reply_q.pop_front()));
            got_st = tx_stat_q.pop_front();
            exp_st = exp_peer_q.pop_front();
            expect_hex("tx_status", 128'(got_st), 128'(exp_st));
        end
        // leftovers would shift the next comparison
        exp_reply_q.delete();
        exp_peer_q.delete();
        tx_byte_q.delete();
        tx_stat_q.delete();
    endtask

    task automatic audit_state();
        expect_hex("pi_enable_cmd", 128'(pi_enable_cmd), 128'(exp_enable));
        expect_hex("pi_reset_cmd", 128'(pi_reset_cmd), 128'(exp_reset));
        expect_hex("pi_params", 128'(pi_params), 128'(exp_params));
        expect_hex("kp_update_cmd count", 128'(kp_pulses), 128'(exp_kp_pulses));
        expect_hex("ti_update_cmd count", 128'(ti_pulses), 128'(exp_ti_pulses));
        expect_hex("setpoint_update_cmd count", 128'(sp_pulses), 128'(exp_sp_pulses));
    endtask

    // wait for every queued reply, then compare
    task automatic settle();
        while (tx_stat_q.size() < exp_peer_q.size()) begin
            tick();
        end
        verify_replies();
        audit_state();
        // whole datagrams consumed
        expect_hex("rx bytes left", 128'(rx_byte_q.size()), 128'(0));
        expect_hex("rx datagrams left", 128'(rx_stat_q.size()), 128'(0));
    endtask

    task automatic finish_test(input string name);
        $display("test %s done, %0d errors", name, test_errors);
        tests++;
        if (test_errors != 0) failed_tests++;
        errors += test_errors;
        test_errors = 0;
    endtask

    function automatic logic [7:0] pick_opcode(input logic control_only);
        int k;
        k = control_only ? int'($urandom % 5) + 2 : int'($urandom % 7);
        case (k)
            0: return op_pi_enable;
            1: return op_pi_reset;
            2: return op_kp;
            3: return op_ti;
            4: return op_setpoint;
            5: return op_limit_hi;
            default: return op_limit_lo;
        endcase
    endfunction

    // mostly in range, now and then too wide
    function automatic logic [31:0] draw_data(input logic [7:0] op);
        int k;
        k = int'($urandom % 8);
        if (op == op_pi_enable || op == op_pi_reset) begin
            return (k < 6) ? 32'($urandom % 2) : $urandom;
        end
        if (k == 0) return $urandom;
        if (op == op_limit_hi || op == op_limit_lo) return 32'($urandom % 32'h4000);
        return 32'($urandom % 32'h0800_0000);
    endfunction

    function automatic logic [7:0] foreign_opcode();
        logic [7:0] op;
        op = 8'($urandom);
        while (op inside {op_pi_enable, op_pi_reset, op_kp, op_ti, op_setpoint,
                          op_limit_hi, op_limit_lo, op_wipe}) begin
            op = 8'($urandom);
        end
        return op;
    endfunction

    initial begin
        logic [7:0] op;
        int         len;
        void'($urandom(32'h510e));
        rst_n <= 1'b0;
        dac_stopped <= 1'b0;
        dac_level = 1'b0;
        rx_data <= 8'h00;
        rx_status <= '0;
        rx_status_empty <= 1'b1;
        tx_data_full <= 1'b0;
        tx_status_full <= 1'b0;
        reset_expected();
        repeat (4) tick();
        rst_n <= 1'b1;

        // defaults, and nothing moves without a datagram
        audit_state();
        repeat (10) begin
            tick();
            expect_hex("rx_data_read", 128'(rx_data_read), 128'(0));
            expect_hex("rx_status_read", 128'(rx_status_read), 128'(0));
            expect_hex("tx_data_write", 128'(tx_data_write), 128'(0));
            expect_hex("tx_status_write", 128'(tx_status_write), 128'(0));
            expect_hex("kp_update_cmd", 128'(kp_update_cmd), 128'(0));
            expect_hex("ti_update_cmd", 128'(ti_update_cmd), 128'(0));
            expect_hex("setpoint_update_cmd", 128'(setpoint_update_cmd), 128'(0));
        end
        finish_test("after_reset");

        repeat (n_flag) begin
            set_dac(1'($urandom % 2));
            op = ($urandom % 2 == 1) ? op_pi_enable : op_pi_reset;
            send_cmd(op, draw_data(op), 8);
            settle();
        end
        finish_test("flag_commands");

        repeat (n_ctrl) begin
            set_dac($urandom % 3 != 0);
            op = pick_opcode(1'b1);
            send_cmd(op, draw_data(op), 8);
            settle();
        end
        finish_test("control_params");

        repeat (n_bad) begin
            set_dac(1'b1);
            if ($urandom % 2 == 1) begin
                len = int'($urandom % 12);
                if (len >= 8) len++;
                send_cmd(pick_opcode(1'b0), $urandom, len);
            end else begin
                send_cmd(foreign_opcode(), $urandom, 8);
            end
            // good command right behind must still parse
            send_cmd(op_setpoint, 32'($urandom % 32'h0800_0000), 8);
            settle();
        end
        finish_test("bad_datagrams");

        set_dac(1'b1);
        repeat (n_wipe) begin
            op = pick_opcode(1'b0);
            send_cmd(op, draw_data(op), 8);
            settle();
        end
        // both flags raised, so the wipe has them to clear
        send_cmd(op_pi_enable, 32'd1, 8);
        send_cmd(op_pi_reset, 32'd1, 8);
        settle();
        send_cmd(op_wipe, $urandom, 8);
        settle();
        finish_test("wipe");

        // all datagrams queued at once, replies in order
        set_dac(1'($urandom % 2));
        repeat (n_burst) begin
            op = pick_opcode(1'b0);
            send_cmd(op, draw_data(op), 8);
        end
        settle();
        finish_test("back_to_back");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+verification
source/pi_cmd_pkg.sv
source/udp_cmd_parser.sv
source/flag_cmd_decoder.sv
source/control_param_decoder.sv
source/ack_frame_builder.sv
source/pi_cmd_top.sv
verification/pi_cmd_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module pi_cmd_tb -f vlog.f -o pi_cmd_sim
./obj_dir/pi_cmd_sim > sim.log 2>&1
cat sim.log
if grep -q "TEST FAILED" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation finished without failures"
